/* verilog/manycore_defs.svh */
//####################################################################
// manycore remote front end geometry
// coordinate widths, mesh size, vcache layout and queue sizing
// shared by both packages and the translator
//####################################################################

`ifndef MANYCORE_DEFS_SVH
`define MANYCORE_DEFS_SVH

// network coordinates
`define X_CORD_WIDTH 4
`define Y_CORD_WIDTH 4
`define EPA_WIDTH 16          // endpoint word address

// mesh of tiles, both powers of two
`define NUM_TILES_X 4
`define NUM_TILES_Y 4

// vcache banks sit on the rows above and below the tiles
`define VCACHE_BLOCK_WORDS 8
`define VCACHE_SIZE_WORDS 1024  // per bank, dram mode off

`define DMEM_START 1024       // word addr of dmem[0] at a tile

`define REQ_FIFO_DEPTH 4      // per requester port
`define NUM_REQ_PORTS 2

`endif

/* verilog/manycore_addr_pkg.sv */
//####################################################################
// manycore address types
// eva class overlays, network physical address and tile-group config
//####################################################################

`include "manycore_defs.svh"
`default_nettype none

package manycore_addr_pkg;

  typedef logic [31:0] eva_t;  // byte address from a requester

  // global class, tag 01
  typedef struct packed {
    logic [1:0]                 remote;
    logic [3:0]                 rsvd;
    logic [`Y_CORD_WIDTH-1:0]   y_cord;
    logic [`X_CORD_WIDTH-1:0]   x_cord;
    logic [`EPA_WIDTH-1:0]      addr;      // word offset at the endpoint
    logic [1:0]                 low_bits;  // byte in word
  } global_addr_s;

  // tile-group class, tag 001, coords relative to the origin
  typedef struct packed {
    logic [2:0]                 remote;
    logic [2:0]                 rsvd;
    logic [`Y_CORD_WIDTH-1:0]   y_cord;
    logic [`X_CORD_WIDTH-1:0]   x_cord;
    logic [`EPA_WIDTH-1:0]      addr;
    logic [1:0]                 low_bits;
  } tile_group_addr_s;

  // tile-group shared class, tag 00001, one flat striped word offset
  typedef struct packed {
    logic [4:0]  remote;
    logic [24:0] addr;
    logic [1:0]  low_bits;
  } shared_addr_s;

  typedef struct packed {
    logic [`X_CORD_WIDTH-1:0] x_cord;
    logic [`Y_CORD_WIDTH-1:0] y_cord;
    logic [`EPA_WIDTH-1:0]    epa;
  } npa_s;

  typedef struct packed {
    logic [`X_CORD_WIDTH-1:0] tgo_x;           // tile-group origin
    logic [`Y_CORD_WIDTH-1:0] tgo_y;
    logic [`X_CORD_WIDTH-1:0] tg_dim_x_width;  // log2 of group dim x
    logic [`Y_CORD_WIDTH-1:0] tg_dim_y_width;
    logic                     dram_enable;     // stripe dram over vcaches
  } tg_cfg_s;

endpackage

`default_nettype wire

/* verilog/manycore_pkt_pkg.sv */
//####################################################################
// manycore network packet types
// opcode, requester port id and the outgoing remote packet
//####################################################################

`include "manycore_defs.svh"
`default_nettype none

package manycore_pkt_pkg;

  typedef enum logic {
    REMOTE_LOAD  = 1'b0,
    REMOTE_STORE = 1'b1
  } remote_op_e;

  // requester index, also the packet source
  typedef logic [$clog2(`NUM_REQ_PORTS)-1:0] port_id_t;

  typedef struct packed {
    port_id_t                 src;   // issuing port
    remote_op_e               op;
    manycore_addr_pkg::npa_s  dest;  // translated destination
    logic [31:0]              data;  // store data, don't care on loads
  } remote_pkt_s;

endpackage

`default_nettype wire

/* verilog/eva_to_npa.sv */
//####################################################################
// eva to npa translator
// maps a 32 bit eva onto x/y coords plus endpoint word address for
// the dram, global, tile-group and tile-group shared classes
//####################################################################

`timescale 1ns/10ps
`include "manycore_defs.svh"
`default_nettype none

module eva_to_npa
  import manycore_addr_pkg::*;
(
  input  eva_t    eva_i,
  input  tg_cfg_s tg_cfg_i,
  output npa_s    npa_o,
  output logic    is_invalid_addr_o
);

  localparam int LG_BLOCK = $clog2(`VCACHE_BLOCK_WORDS);
  localparam int LG_BANKS = $clog2(2 * `NUM_TILES_X);  // banks above and below
  localparam int LG_TX    = $clog2(`NUM_TILES_X);
  localparam int LG_VC    = $clog2(`VCACHE_SIZE_WORDS);
  localparam int BLOCK_W  = 30 - LG_BLOCK;
  localparam int SH_W     = $bits(shared_addr_s) - 7;  // shared word offset

  global_addr_s     global_addr;
  tile_group_addr_s tg_addr;
  shared_addr_s     shared_addr;

  logic [29:0]               word_idx;
  logic [BLOCK_W-1:0]        block;
  logic [LG_BANKS-1:0]       bank;
  logic [BLOCK_W-LG_BANKS-1:0] bank_index;

  logic [SH_W-1:0] sh_x_bits, sh_y_bits, sh_rest;
  logic [5:0]      sh_amt;

  logic is_dram, is_global, is_tg, is_shared;

  assign global_addr = eva_i;  // same bits, per-class view
  assign tg_addr     = eva_i;
  assign shared_addr = eva_i;

  assign is_dram   = eva_i[31];
  assign is_global = global_addr.remote == 2'b01;
  assign is_tg     = tg_addr.remote == 3'b001;
  assign is_shared = shared_addr.remote == 5'b00001;

  assign is_invalid_addr_o = ~(is_dram | is_global | is_tg | is_shared);

  // dram striping, modulo on the block number
  assign word_idx   = eva_i[31:2];
  assign block      = word_idx[LG_BLOCK +: BLOCK_W];
  assign bank       = block[LG_BANKS-1:0];        // {bot_not_top, x}
  assign bank_index = block[BLOCK_W-1:LG_BANKS];  // block within bank

  // shared: low bits pick x, next bits pick y, rest is dmem offset
  assign sh_x_bits = shared_addr.addr & ~({SH_W{1'b1}} << tg_cfg_i.tg_dim_x_width);
  assign sh_y_bits = (shared_addr.addr >> tg_cfg_i.tg_dim_x_width)
                   & ~({SH_W{1'b1}} << tg_cfg_i.tg_dim_y_width);
  assign sh_amt    = 6'(tg_cfg_i.tg_dim_x_width) + 6'(tg_cfg_i.tg_dim_y_width);
  assign sh_rest   = shared_addr.addr >> sh_amt;

  always_comb begin
    npa_o = '0;  // invalid class, ignored by the port
    if (is_dram) begin
      if (tg_cfg_i.dram_enable) begin
        npa_o.x_cord = `X_CORD_WIDTH'(bank[LG_TX-1:0]);
        npa_o.y_cord = bank[LG_BANKS-1] ? `Y_CORD_WIDTH'(`NUM_TILES_Y + 1) : '0;
        npa_o.epa    = `EPA_WIDTH'({bank_index, word_idx[LG_BLOCK-1:0]});
      end else if (eva_i[30]) begin
        // host memory behind (0,1)
        npa_o.x_cord = '0;
        npa_o.y_cord = `Y_CORD_WIDTH'(1);
        npa_o.epa    = {1'b1, word_idx[`EPA_WIDTH-2:0]};
      end else begin
        // vcache as plain block memory
        npa_o.x_cord = `X_CORD_WIDTH'(word_idx[LG_VC +: LG_TX]);
        npa_o.y_cord = word_idx[LG_VC+LG_TX] ? `Y_CORD_WIDTH'(`NUM_TILES_Y + 1) : '0;
        npa_o.epa    = `EPA_WIDTH'(word_idx[LG_VC-1:0]);
      end
    end else if (is_global) begin
      npa_o.x_cord = global_addr.x_cord;  // coords straight from eva
      npa_o.y_cord = global_addr.y_cord;
      npa_o.epa    = global_addr.addr;
    end else if (is_tg) begin
      npa_o.x_cord = tg_addr.x_cord + tg_cfg_i.tgo_x;  // wraps at coord width
      npa_o.y_cord = tg_addr.y_cord + tg_cfg_i.tgo_y;
      npa_o.epa    = tg_addr.addr;
    end else if (is_shared) begin
      npa_o.x_cord = `X_CORD_WIDTH'(sh_x_bits) + tg_cfg_i.tgo_x;
      npa_o.y_cord = `Y_CORD_WIDTH'(sh_y_bits) + tg_cfg_i.tgo_y;
      npa_o.epa    = `EPA_WIDTH'(sh_rest + SH_W'(`DMEM_START));
    end
  end

endmodule

`default_nettype wire

/* verilog/remote_req_fifo.sv */
//####################################################################
// remote request fifo
// small circular queue of remote packets with full and empty flags
//####################################################################

`timescale 1ns/10ps
`include "manycore_defs.svh"
`default_nettype none

module remote_req_fifo
  import manycore_pkt_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        push_i,
  input  remote_pkt_s push_pkt_i,
  input  logic        pop_i,
  output remote_pkt_s head_pkt_o,
  output logic        empty_o,
  output logic        full_o
);

  localparam int DEPTH = `REQ_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  remote_pkt_s      mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // wrap
  endfunction

  assign empty_o    = count_q == '0;
  assign full_o     = count_q == CNT_W'(DEPTH);
  assign head_pkt_o = mem_q[rd_ptr_q];  // head visible the cycle after push

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_pkt_i;
  end

  // requester must respect ready, arbiter only pops a valid head
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o) else $error("remote_req_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o) else $error("remote_req_fifo: pop while empty");

endmodule

`default_nettype wire

/* verilog/remote_req_port.sv */
//####################################################################
// remote request port
// translates one requester's eva, queues valid packets and turns
// unmapped addresses into a one cycle fault pulse
//####################################################################

`timescale 1ns/10ps
`default_nettype none

module remote_req_port
  import manycore_addr_pkg::*;
  import manycore_pkt_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  port_id_t    port_id_i,   // tied per instance
  input  tg_cfg_s     tg_cfg_i,
  input  logic        req_v_i,     // one cycle strobe
  input  remote_op_e  req_op_i,
  input  eva_t        req_eva_i,
  input  logic [31:0] req_data_i,
  output logic        req_ready_o,
  output logic        fault_o,
  output eva_t        fault_eva_o,
  output logic        head_v_o,
  output remote_pkt_s head_pkt_o,
  input  logic        pop_i        // grant from arbiter
);

  npa_s        npa;
  logic        is_invalid;
  remote_pkt_s req_pkt;
  logic        full, empty;

  eva_to_npa eva_to_npa_inst (
    .eva_i             (req_eva_i),
    .tg_cfg_i          (tg_cfg_i),
    .npa_o             (npa),
    .is_invalid_addr_o (is_invalid)
  );

  assign req_pkt = '{src: port_id_i, op: req_op_i, dest: npa, data: req_data_i};

  remote_req_fifo remote_req_fifo_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .push_i     (req_v_i & ~is_invalid),  // faults never queued
    .push_pkt_i (req_pkt),
    .pop_i      (pop_i),
    .head_pkt_o (head_pkt_o),
    .empty_o    (empty),
    .full_o     (full)
  );

  assign req_ready_o = ~full;
  assign head_v_o    = ~empty;

  // fault flag, reported the cycle after the strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) fault_o <= 1'b0;
    else           fault_o <= req_v_i & is_invalid;
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && is_invalid) fault_eva_o <= req_eva_i;  // offending eva
  end

  // an accepted request shows up at the queue head next cycle
  a_push_to_head: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_v_i && !is_invalid && !full |=> head_v_o)
    else $error("remote_req_port: accepted request not at queue head");

endmodule

`default_nettype wire

/* verilog/remote_bus_arbiter.sv */
//####################################################################
// remote bus arbiter
// round robin grant of the port queue heads onto the one outgoing
// network bus, grant locked while the bus back-pressures
//####################################################################

`timescale 1ns/10ps
`include "manycore_defs.svh"
`default_nettype none

module remote_bus_arbiter
  import manycore_pkt_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [`NUM_REQ_PORTS-1:0] head_v_i,
  input  remote_pkt_s               head_pkt_i [`NUM_REQ_PORTS],
  output logic [`NUM_REQ_PORTS-1:0] pop_o,      // one-hot
  output logic                      bus_v_o,
  output remote_pkt_s               bus_pkt_o,
  input  logic                      bus_ready_i
);

  localparam int NUM = `NUM_REQ_PORTS;

  port_id_t rr_ptr_q;   // first port to look at
  port_id_t grant_q;    // held grant under back-pressure
  logic     locked_q;
  port_id_t pick_idx, grant_idx;
  logic     pick_found, xfer;

  // first valid head at or after the pointer
  always_comb begin
    int unsigned idx;
    pick_found = 1'b0;
    pick_idx   = rr_ptr_q;
    for (int i = 0; i < NUM; i++) begin
      idx = (int'(rr_ptr_q) + i) % NUM;
      if (!pick_found && head_v_i[idx]) begin
        pick_found = 1'b1;
        pick_idx   = port_id_t'(idx);
      end
    end
  end

  assign grant_idx = locked_q ? grant_q : pick_idx;
  assign bus_v_o   = pick_found;  // locked head stays valid until popped
  assign bus_pkt_o = head_pkt_i[grant_idx];
  assign xfer      = bus_v_o & bus_ready_i;

  always_comb begin
    pop_o = '0;
    if (xfer) pop_o[grant_idx] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
      grant_q  <= '0;
      locked_q <= 1'b0;
    end else if (xfer) begin
      rr_ptr_q <= (int'(grant_idx) == NUM - 1) ? '0 : grant_idx + 1'b1;
      locked_q <= 1'b0;
    end else if (bus_v_o) begin
      grant_q  <= grant_idx;  // stalled, hold this port
      locked_q <= 1'b1;
    end
  end

  // packet must not change while the bus stalls it
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bus_v_o && !bus_ready_i |=> bus_v_o && $stable(bus_pkt_o))
    else $error("remote_bus_arbiter: bus packet changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/manycore_remote_top.sv */
//####################################################################
// manycore remote request front end
// requester ports feeding one round robin arbiter on the network bus
//####################################################################

`timescale 1ns/10ps
`include "manycore_defs.svh"
`default_nettype none

module manycore_remote_top
  import manycore_addr_pkg::*;
  import manycore_pkt_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  tg_cfg_s                   tg_cfg_i,  // shared by all ports
  input  logic [`NUM_REQ_PORTS-1:0] req_v_i,
  input  remote_op_e                req_op_i    [`NUM_REQ_PORTS],
  input  eva_t                      req_eva_i   [`NUM_REQ_PORTS],
  input  logic [31:0]               req_data_i  [`NUM_REQ_PORTS],
  output logic [`NUM_REQ_PORTS-1:0] req_ready_o,
  output logic [`NUM_REQ_PORTS-1:0] fault_o,
  output eva_t                      fault_eva_o [`NUM_REQ_PORTS],
  output logic                      bus_v_o,
  output remote_pkt_s               bus_pkt_o,
  input  logic                      bus_ready_i
);

  logic [`NUM_REQ_PORTS-1:0] head_v;
  remote_pkt_s               head_pkt [`NUM_REQ_PORTS];
  logic [`NUM_REQ_PORTS-1:0] pop;

  for (genvar i = 0; i < `NUM_REQ_PORTS; i++) begin : g_port
    remote_req_port remote_req_port_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .port_id_i   (port_id_t'(i)),  // packet source id
      .tg_cfg_i    (tg_cfg_i),
      .req_v_i     (req_v_i[i]),
      .req_op_i    (req_op_i[i]),
      .req_eva_i   (req_eva_i[i]),
      .req_data_i  (req_data_i[i]),
      .req_ready_o (req_ready_o[i]),
      .fault_o     (fault_o[i]),
      .fault_eva_o (fault_eva_o[i]),
      .head_v_o    (head_v[i]),
      .head_pkt_o  (head_pkt[i]),
      .pop_i       (pop[i])
    );
  end

  remote_bus_arbiter remote_bus_arbiter_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .head_v_i    (head_v),
    .head_pkt_i  (head_pkt),
    .pop_o       (pop),
    .bus_v_o     (bus_v_o),
    .bus_pkt_o   (bus_pkt_o),
    .bus_ready_i (bus_ready_i)
  );

endmodule

`default_nettype wire

/* tb/tb_remote_model.svh */
//####################################################################
// remote front end reference model
// eva translation from the address class rules, expected per-port
// queues, round robin pointer and the typed compare tasks
//####################################################################

`ifndef TB_REMOTE_MODEL_SVH
`define TB_REMOTE_MODEL_SVH

remote_pkt_s exp_q [NP][$];   // what each port fifo should hold
int unsigned rr_ptr;          // first port the arbiter looks at
bit          grant_locked;    // bus stalled on grant_port
int unsigned grant_port;
bit          fault_due [NP];  // fault expected at the next sample
eva_t        fault_exp [NP];

// returns 0 for an eva in no class
function automatic bit translate_eva(input eva_t eva, input tg_cfg_s cfg, output npa_s npa);
  longint unsigned  w, b, bank, off;
  int               dx, dy;
  global_addr_s     g;
  tile_group_addr_s t;
  w   = 64'(eva >> 2);  // word index
  off = 64'(eva[26:2]); // shared word offset
  dx  = int'(cfg.tg_dim_x_width);
  dy  = int'(cfg.tg_dim_y_width);
  g   = eva;
  t   = eva;
  npa = '0;
  if (eva[31] && cfg.dram_enable) begin
    b    = w / `VCACHE_BLOCK_WORDS;
    bank = b % (2 * `NUM_TILES_X);
    npa.x_cord = `X_CORD_WIDTH'(bank % `NUM_TILES_X);
    npa.y_cord = (bank >= `NUM_TILES_X) ? `Y_CORD_WIDTH'(`NUM_TILES_Y + 1) : '0;
    npa.epa    = `EPA_WIDTH'((b / (2 * `NUM_TILES_X)) * `VCACHE_BLOCK_WORDS
                             + w % `VCACHE_BLOCK_WORDS);
  end else if (eva[31] && eva[30]) begin
    npa.y_cord = `Y_CORD_WIDTH'(1);  // host memory at (0,1)
    npa.epa    = `EPA_WIDTH'((1 << (`EPA_WIDTH - 1)) + w % (1 << (`EPA_WIDTH - 1)));
  end else if (eva[31]) begin
    npa.x_cord = `X_CORD_WIDTH'((w / `VCACHE_SIZE_WORDS) % `NUM_TILES_X);
    npa.y_cord = ((w / (`VCACHE_SIZE_WORDS * `NUM_TILES_X)) % 2 == 1)
               ? `Y_CORD_WIDTH'(`NUM_TILES_Y + 1) : '0;  // bottom row
    npa.epa    = `EPA_WIDTH'(w % `VCACHE_SIZE_WORDS);
  end else if (eva[31:30] == 2'b01) begin
    npa.x_cord = g.x_cord;
    npa.y_cord = g.y_cord;
    npa.epa    = g.addr;
  end else if (eva[31:29] == 3'b001) begin
    npa.x_cord = `X_CORD_WIDTH'((t.x_cord + cfg.tgo_x) % (1 << `X_CORD_WIDTH));
    npa.y_cord = `Y_CORD_WIDTH'((t.y_cord + cfg.tgo_y) % (1 << `Y_CORD_WIDTH));
    npa.epa    = t.addr;
  end else if (eva[31:27] == 5'b00001) begin
    npa.x_cord = `X_CORD_WIDTH'((off % (1 << dx) + cfg.tgo_x) % (1 << `X_CORD_WIDTH));
    npa.y_cord = `Y_CORD_WIDTH'(((off >> dx) % (1 << dy) + cfg.tgo_y) % (1 << `Y_CORD_WIDTH));
    npa.epa    = `EPA_WIDTH'((off >> (dx + dy)) + `DMEM_START);
  end else begin
    return 1'b0;
  end
  return 1'b1;
endfunction

// first port with a queued packet at or after the pointer
function automatic int unsigned pick_grant();
  for (int k = 0; k < NP; k++) begin
    if (exp_q[(rr_ptr + k) % NP].size() != 0) return (rr_ptr + k) % NP;
  end
  return rr_ptr;
endfunction

task automatic check_pkt(input string name, input remote_pkt_s exp, input remote_pkt_s act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end_with_failure();
  end
endtask

task automatic check_fault(input string name, input eva_t exp, input eva_t act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end_with_failure();
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end_with_failure();
  end
endtask

`endif

/* tb/tb_manycore_remote.sv */
//####################################################################
// remote front end testbench
// random requests on both ports under bus back-pressure, every bus
// packet and fault checked against the reference model
//####################################################################

`timescale 1ns/10ps
`include "manycore_defs.svh"
`default_nettype none

module tb_manycore_remote
  import manycore_addr_pkg::*;
  import manycore_pkt_pkg::*;
();

  localparam int NP             = `NUM_REQ_PORTS;
  localparam int DEPTH          = `REQ_FIFO_DEPTH;
  localparam int REQS_PER_PHASE = 40;  // per port
  localparam int NUM_PHASES     = 6;
  localparam int TOTAL_REQS     = NP * REQS_PER_PHASE * NUM_PHASES;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 20 + 500;

  // eva kinds, ranges of these pick a phase's mix
  localparam int K_GLOBAL = 0;
  localparam int K_TG     = 1;
  localparam int K_SHARED = 2;
  localparam int K_BAD    = 3;
  localparam int K_DRAM   = 4;

  logic        clk, arst_n;
  tg_cfg_s     tg_cfg;
  logic [NP-1:0] req_v, req_ready, fault;
  remote_op_e  req_op [NP];
  eva_t        req_eva [NP];
  logic [31:0] req_data [NP];
  eva_t        fault_eva [NP];
  logic        bus_v, bus_ready;
  remote_pkt_s bus_pkt;

  integer seed = 36234;
  string  test_name;
  int     issued [NP];  // strobes in the current phase

  manycore_remote_top manycore_remote_top_inst (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .tg_cfg_i    (tg_cfg),
    .req_v_i     (req_v),
    .req_op_i    (req_op),
    .req_eva_i   (req_eva),
    .req_data_i  (req_data),
    .req_ready_o (req_ready),
    .fault_o     (fault),
    .fault_eva_o (fault_eva),
    .bus_v_o     (bus_v),
    .bus_pkt_o   (bus_pkt),
    .bus_ready_i (bus_ready)
  );

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_remote_model.svh"

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $unsigned($random(seed));
    return int'(r % n);
  endfunction

  function automatic eva_t gen_eva(input int kind);
    eva_t r;
    r = $random(seed);
    case (kind)
      K_GLOBAL: r[31:30] = 2'b01;
      K_TG:     r[31:29] = 3'b001;
      K_SHARED: r[31:27] = 5'b00001;
      K_BAD: begin
        r[31:28] = rand_below(2) == 1 ? 4'b0000 : 4'b0001;  // 00000 or 0001x
        if (r[31:28] == 4'b0000) r[27] = 1'b0;
      end
      default:  r[31] = 1'b1;  // dram, bit 30 random
    endcase
    return r;
  endfunction

  function automatic tg_cfg_s random_cfg(input logic dram_en);
    tg_cfg_s c;
    c.tgo_x          = `X_CORD_WIDTH'(rand_below(1 << `X_CORD_WIDTH));
    c.tgo_y          = `Y_CORD_WIDTH'(rand_below(1 << `Y_CORD_WIDTH));
    c.tg_dim_x_width = `X_CORD_WIDTH'(rand_below(3));  // groups up to 4x4
    c.tg_dim_y_width = `Y_CORD_WIDTH'(rand_below(3));
    c.dram_enable    = dram_en;
    return c;
  endfunction

  function automatic bit phase_drained();
    for (int i = 0; i < NP; i++) begin
      if (issued[i] < REQS_PER_PHASE || exp_q[i].size() != 0 || fault_due[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // mid-cycle sample, all dut outputs settled
  task automatic monitor_step();
    npa_s npa;
    logic any_head;
    any_head = 1'b0;
    for (int i = 0; i < NP; i++) begin
      check_flag($sformatf("%s ready port %0d", test_name, i), exp_q[i].size() < DEPTH,
                 req_ready[i]);
      check_flag($sformatf("%s fault port %0d", test_name, i), fault_due[i], fault[i]);
      if (fault_due[i]) check_fault({test_name, " fault eva"}, fault_exp[i], fault_eva[i]);
      if (exp_q[i].size() != 0) any_head = 1'b1;
    end
    check_flag({test_name, " bus valid"}, any_head, bus_v);
    if (bus_v) begin
      if (!grant_locked) begin
        grant_port   = pick_grant();
        grant_locked = 1'b1;  // held until the transfer
      end
      check_pkt({test_name, " bus packet"}, exp_q[grant_port][0], bus_pkt);
      if (bus_ready) begin
        void'(exp_q[grant_port].pop_front());
        rr_ptr       = (grant_port + 1) % NP;
        grant_locked = 1'b0;
      end
    end
    // strobes taken at the coming edge
    for (int i = 0; i < NP; i++) begin
      fault_due[i] = 1'b0;
      if (req_v[i]) begin
        if (translate_eva(req_eva[i], tg_cfg, npa)) begin
          exp_q[i].push_back('{src: port_id_t'(i), op: req_op[i], dest: npa,
                               data: req_data[i]});
        end else begin
          fault_due[i] = 1'b1;
          fault_exp[i] = req_eva[i];
        end
      end
    end
  endtask

  task automatic drive_step(input int kind_lo, input int kind_hi, input int strobe_pct,
                            input int ready_pct);
    remote_op_e op;
    for (int i = 0; i < NP; i++) begin
      // model size matches the fifo count seen at the next edge
      if (issued[i] < REQS_PER_PHASE && exp_q[i].size() < DEPTH
          && rand_below(100) < strobe_pct) begin
        op = rand_below(2) == 1 ? REMOTE_STORE : REMOTE_LOAD;
        req_v[i]    <= 1'b1;
        req_op[i]   <= op;
        req_eva[i]  <= gen_eva(kind_lo + rand_below(kind_hi - kind_lo + 1));
        req_data[i] <= (op == REMOTE_STORE) ? 32'($random(seed)) : '0;
        issued[i]++;
      end else begin
        req_v[i] <= 1'b0;
      end
    end
    bus_ready <= rand_below(100) < ready_pct;
  endtask

  task automatic run_phase(input string name, input logic dram_en, input int kind_lo,
                           input int kind_hi, input int strobe_pct, input int ready_pct);
    test_name = name;
    issued    = '{default: 0};
    @(posedge clk);
    tg_cfg <= random_cfg(dram_en);  // ports idle here
    forever begin
      @(negedge clk);
      monitor_step();
      if (phase_drained()) break;
      @(posedge clk);
      drive_step(kind_lo, kind_hi, strobe_pct, ready_pct);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: requests not drained after %0d cycles", TIMEOUT_CYCLES);
    end_with_failure();
  end

  initial begin
    arst_n    = 1'b0;
    tg_cfg    = '0;
    req_v     = '0;
    bus_ready = 1'b0;
    for (int i = 0; i < NP; i++) begin
      req_op[i]    = REMOTE_LOAD;
      req_eva[i]   = '0;
      req_data[i]  = '0;
      fault_due[i] = 1'b0;
    end
    rr_ptr       = 0;
    grant_locked = 1'b0;
    test_name    = "reset";
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    monitor_step();  // idle outputs right after reset

    run_phase("global_tg", rand_below(2) == 1, K_GLOBAL, K_TG, 50, 70);
    run_phase("dram_on", 1'b1, K_DRAM, K_DRAM, 50, 70);
    run_phase("dram_off", 1'b0, K_DRAM, K_DRAM, 50, 70);
    run_phase("shared", rand_below(2) == 1, K_SHARED, K_SHARED, 50, 70);
    run_phase("invalid", 1'b1, K_GLOBAL, K_BAD, 50, 70);
    run_phase("arbitration", rand_below(2) == 1, K_GLOBAL, K_DRAM, 90, 30);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
+incdir+tb
verilog/manycore_addr_pkg.sv
verilog/manycore_pkt_pkg.sv
verilog/eva_to_npa.sv
verilog/remote_req_fifo.sv
verilog/remote_req_port.sv
verilog/remote_bus_arbiter.sv
verilog/manycore_remote_top.sv
tb/tb_manycore_remote.sv

/* Bender.yml */
package:
  name: manycore_remote

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/manycore_addr_pkg.sv
      - verilog/manycore_pkt_pkg.sv
      - verilog/eva_to_npa.sv
      - verilog/remote_req_fifo.sv
      - verilog/remote_req_port.sv
      - verilog/remote_bus_arbiter.sv
      - verilog/manycore_remote_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_manycore_remote.sv
